// ==== src/maxpool_pkg.sv ====
// Max-pooling engine shared definitions
// Pooling state encoding, user field bit positions and default sizes
`default_nettype none

package maxpool_pkg;

  // *************************************************************************
  // Pooling state
  // *************************************************************************

  // MAX_2 covers the first block of a max pair and all non-max traffic
  // MAX_4 covers the second block, where four words meet per lane
  typedef enum logic {
    MAX_2_S = 1'b0,
    MAX_4_S = 1'b1
  } pool_state_e;

  // *************************************************************************
  // User field layout
  // *************************************************************************

  // Two mode bits, both may be set at once
  localparam int USER_WIDTH   = 2;
  // Pass every beat through
  localparam int I_IS_NOT_MAX = 0;
  // Pool block pairs 2x2
  localparam int I_IS_MAX     = 1;

  // *************************************************************************
  // Default sizes
  // *************************************************************************

  // Taken by the top level as its parameter defaults
  localparam int DEF_UNITS      = 4;
  localparam int DEF_GROUPS     = 2;
  // Beats per block, at least 2
  localparam int DEF_MEMBERS    = 4;
  // Signed word width
  localparam int DEF_WORD_WIDTH = 8;

endpackage

`default_nettype wire

// ==== src/member_counter.sv ====
// Member counter
// Counts accepted beats modulo MEMBERS and flags the last beat of a block
`timescale 1ns/1ps
`default_nettype none

module member_counter #(
  parameter int MEMBERS = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       beat,
  output logic [$clog2(MEMBERS)-1:0] count,
  output logic                       block_end
);

  localparam int COUNT_WIDTH = $clog2(MEMBERS);

  // Position of the final member in a block
  localparam logic [COUNT_WIDTH-1:0] LAST_MEMBER = COUNT_WIDTH'(MEMBERS - 1);

  logic at_last;

  // Last position decode
  assign at_last = (count == LAST_MEMBER);

  // Only an accepted beat can close a block
  assign block_end = beat && at_last;

  // Wrap explicitly, MEMBERS need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (beat) begin
      if (at_last) begin
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/maxpool_fsm.sv ====
// Max-pooling control
// Tracks MAX_2/MAX_4 blocks, stalls the source after MAX_4 beats, gates the
// row buffer enables and times the valid and last flags of pooled beats
`timescale 1ns/1ps
`default_nettype none

module maxpool_fsm (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                beat,
  input  logic                                block_end,
  input  logic [maxpool_pkg::USER_WIDTH-1:0]  user,
  output maxpool_pkg::pool_state_e            state,
  output logic                                stall,
  output logic                                buf_head_en,
  output logic                                buf_shift_en,
  output logic                                max_valid,
  output logic                                max_last
);

  import maxpool_pkg::*;

  logic is_max;
  logic is_both;
  logic max_4_beat;

  // Pipeline stage between handshake and pooled output
  logic max_valid_q;
  logic max_last_q;

  assign is_max     = user[I_IS_MAX];
  assign is_both    = user[I_IS_MAX] && user[I_IS_NOT_MAX];
  assign max_4_beat = beat && (state == MAX_4_S);

  // *************************************************************************
  // State and stall
  // *************************************************************************

  // Flip at each block boundary of max traffic
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= MAX_2_S;
    end else if (block_end && is_max) begin
      state <= (state == MAX_2_S) ? MAX_4_S : MAX_2_S;
    end
  end

  // One free cycle after every MAX_4 beat
  // Comparator then works on buffered values instead of the input
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stall <= 1'b0;
    end else begin
      stall <= max_4_beat;
    end
  end

  // *************************************************************************
  // Row buffer enables
  // *************************************************************************

  // Head also loads the four-word max during the stall
  assign buf_head_en  = is_max && (beat || stall);
  // Rest of the chain moves only with accepted beats
  assign buf_shift_en = is_max && beat;

  // *************************************************************************
  // Pooled beat flags
  // *************************************************************************

  // Two stages, matching compare-then-register in the datapath
  // In both mode every MAX_4 output closes a packet
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      max_valid_q <= 1'b0;
      max_last_q  <= 1'b0;
      max_valid   <= 1'b0;
      max_last    <= 1'b0;
    end else begin
      max_valid_q <= max_4_beat && is_max;
      max_last_q  <= max_4_beat && is_max && (block_end || is_both);
      max_valid   <= max_valid_q;
      max_last    <= max_last_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/max_datapath.sv ====
// Max-pooling datapath
// Per-lane signed comparators with input muxes and a MEMBERS+1 deep row
// buffer that holds the first block of a pair until its partner arrives
`timescale 1ns/1ps
`default_nettype none

module max_datapath #(
  parameter int UNITS      = 4,
  parameter int GROUPS     = 2,
  parameter int MEMBERS    = 4,
  parameter int WORD_WIDTH = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] s_data,
  input  logic                                 stall,
  input  logic                                 buf_head_en,
  input  logic                                 buf_shift_en,
  output logic [GROUPS*UNITS*WORD_WIDTH-1:0]   pooled
);

  // Lanes ordered group, unit
  localparam int LANES = GROUPS * UNITS;

  // Copy 1 sits above copy 0 in the flat input
  localparam int COPY_1_BASE = LANES * WORD_WIDTH;

  // *************************************************************************
  // Per-lane pooling
  // *************************************************************************
  //
  // First block (MAX_2)
  //   head <= max(copy 0, copy 1), chain shifts one place per beat
  // Second block (MAX_4), beat cycle
  //   head <= max(copy 0, copy 1) of the new row
  //   tail now holds the same column of the stored row
  // Stall cycle
  //   head <= max(head, tail), the four-word max
  //   chain does not move, so the stored row stays aligned

  for (genvar l = 0; l < LANES; l++) begin : g_lane

    logic signed [WORD_WIDTH-1:0] copy_0;
    logic signed [WORD_WIDTH-1:0] copy_1;
    logic signed [WORD_WIDTH-1:0] cmp_a;
    logic signed [WORD_WIDTH-1:0] cmp_b;
    logic signed [WORD_WIDTH-1:0] cmp_max;

    // Index 0 is the head, index MEMBERS the oldest entry
    logic signed [WORD_WIDTH-1:0] row_buf [MEMBERS+1];

    // Two vertical neighbours of this lane
    assign copy_0 = s_data[l*WORD_WIDTH +: WORD_WIDTH];
    assign copy_1 = s_data[COPY_1_BASE + l*WORD_WIDTH +: WORD_WIDTH];

    // Comparator input muxes
    assign cmp_a = stall ? row_buf[0]       : copy_0;
    assign cmp_b = stall ? row_buf[MEMBERS] : copy_1;

    // Signed compare, ties take either side
    assign cmp_max = (cmp_a > cmp_b) ? cmp_a : cmp_b;

    // Head register and the shift chain behind it
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        for (int m = 0; m <= MEMBERS; m++) begin
          row_buf[m] <= '0;
        end
      end else begin
        if (buf_head_en) begin
          row_buf[0] <= cmp_max;
        end
        if (buf_shift_en) begin
          for (int m = 1; m <= MEMBERS; m++) begin
            row_buf[m] <= row_buf[m-1];
          end
        end
      end
    end

    // Head holds the pooled word one cycle after the stall
    assign pooled[l*WORD_WIDTH +: WORD_WIDTH] = row_buf[0];

  end

endmodule

`default_nettype wire

// ==== src/pool_output.sv ====
// Max-pooling output stage
// Delays pass-through beats by one cycle and merges them with pooled beats
// onto the output stream, with keep pattern, valid and packet last
`timescale 1ns/1ps
`default_nettype none

module pool_output #(
  parameter int UNITS      = 4,
  parameter int GROUPS     = 2,
  parameter int WORD_WIDTH = 8
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 beat,
  input  logic                                 block_end,
  input  logic [maxpool_pkg::USER_WIDTH-1:0]   user,
  input  maxpool_pkg::pool_state_e             state,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] s_data,
  input  logic [GROUPS*UNITS*WORD_WIDTH-1:0]   pooled,
  input  logic                                 max_valid,
  input  logic                                 max_last,
  output logic                                 m_valid,
  output logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] m_data,
  output logic [2*GROUPS*UNITS-1:0]            m_keep,
  output logic                                 m_last
);

  import maxpool_pkg::*;

  localparam int LANES  = GROUPS * UNITS;
  // Bits in one copy
  localparam int HALF_W = LANES * WORD_WIDTH;

  logic                     pass_beat;
  logic                     pass_last_next;
  logic [2*HALF_W-1:0]      pass_data;
  logic                     pass_valid;
  logic                     pass_last;

  // *************************************************************************
  // Pass-through delay
  // *************************************************************************

  assign pass_beat = beat && user[I_IS_NOT_MAX];

  // Both modes in MAX_4 send one beat per packet
  assign pass_last_next = block_end ||
                          (user[I_IS_MAX] && user[I_IS_NOT_MAX] && (state == MAX_4_S));

  // Beat payload, loaded only when it is going out
  always_ff @(posedge clk) begin
    if (pass_beat) begin
      pass_data <= s_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pass_valid <= 1'b0;
      pass_last  <= 1'b0;
    end else begin
      pass_valid <= pass_beat;
      pass_last  <= pass_beat && pass_last_next;
    end
  end

  // *************************************************************************
  // Output mux
  // *************************************************************************

  // Stall keeps the two sources in separate cycles
  assign m_valid = pass_valid || max_valid;

  // Pooled word replaces copy 0, copy 1 is left as is
  assign m_data = {pass_data[2*HALF_W-1:HALF_W],
                   max_valid ? pooled : pass_data[HALF_W-1:0]};

  // Pooled beats drop copy 1
  assign m_keep = {{LANES{~max_valid}}, {LANES{1'b1}}};

  // Last only alongside a valid beat
  assign m_last = max_valid ? max_last : (pass_valid && pass_last);

endmodule

`default_nettype wire

// ==== src/maxpool_engine.sv ====
// Streaming 2x2 max-pooling engine
// Passes beats through, pools block pairs, or both, on a valid/ready input
// stream and a valid-only output stream
`timescale 1ns/1ps
`default_nettype none

module maxpool_engine #(
  parameter int UNITS      = maxpool_pkg::DEF_UNITS,
  parameter int GROUPS     = maxpool_pkg::DEF_GROUPS,
  parameter int MEMBERS    = maxpool_pkg::DEF_MEMBERS,
  parameter int WORD_WIDTH = maxpool_pkg::DEF_WORD_WIDTH
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Input stream
  input  logic                                 s_valid,
  input  logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] s_data,
  input  logic [maxpool_pkg::USER_WIDTH-1:0]   s_user,
  output logic                                 s_ready,
  // Output stream, always accepted
  output logic                                 m_valid,
  output logic [2*GROUPS*UNITS*WORD_WIDTH-1:0] m_data,
  output logic [2*GROUPS*UNITS-1:0]            m_keep,
  output logic                                 m_last
);

  import maxpool_pkg::*;

  logic                             beat;
  logic                             block_end;
  pool_state_e                      state;
  logic                             stall;
  logic                             buf_head_en;
  logic                             buf_shift_en;
  logic                             max_valid;
  logic                             max_last;
  logic [GROUPS*UNITS*WORD_WIDTH-1:0] pooled;

  // Source is held off during the comparator's stall cycle
  assign s_ready = ~stall;
  assign beat    = s_valid && s_ready;

  // Block position
  member_counter #(
    .MEMBERS      (MEMBERS)
  ) u_member_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat         (beat),
    .count        (),
    .block_end    (block_end)
  );

  // Control
  maxpool_fsm u_maxpool_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat         (beat),
    .block_end    (block_end),
    .user         (s_user),
    .state        (state),
    .stall        (stall),
    .buf_head_en  (buf_head_en),
    .buf_shift_en (buf_shift_en),
    .max_valid    (max_valid),
    .max_last     (max_last)
  );

  // Comparators and row buffer
  max_datapath #(
    .UNITS        (UNITS),
    .GROUPS       (GROUPS),
    .MEMBERS      (MEMBERS),
    .WORD_WIDTH   (WORD_WIDTH)
  ) u_max_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .s_data       (s_data),
    .stall        (stall),
    .buf_head_en  (buf_head_en),
    .buf_shift_en (buf_shift_en),
    .pooled       (pooled)
  );

  // Output merge
  pool_output #(
    .UNITS        (UNITS),
    .GROUPS       (GROUPS),
    .WORD_WIDTH   (WORD_WIDTH)
  ) u_pool_output (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat         (beat),
    .block_end    (block_end),
    .user         (s_user),
    .state        (state),
    .s_data       (s_data),
    .pooled       (pooled),
    .max_valid    (max_valid),
    .max_last     (max_last),
    .m_valid      (m_valid),
    .m_data       (m_data),
    .m_keep       (m_keep),
    .m_last       (m_last)
  );

endmodule

`default_nettype wire

// ==== test/maxpool_engine_assertions.sv ====
// Bound protocol checks for the max-pooling engine
// Stall timing, output latency, keep patterns and packet last flags
`timescale 1ns/1ps
`default_nettype none

module maxpool_engine_assertions #(
  parameter int LANES = 8
) (
  input logic                               clk,
  input logic                               rst_n,
  input logic                               beat,
  input logic                               s_ready,
  input logic [maxpool_pkg::USER_WIDTH-1:0] s_user,
  input maxpool_pkg::pool_state_e           state,
  input logic                               m_valid,
  input logic [2*LANES-1:0]                 m_keep,
  input logic                               m_last
);

  import maxpool_pkg::*;

  // Tally read by the testbench
  int   fail_count = 0;
  logic seen_beat;
  logic max_4_beat;

  assign max_4_beat = beat && (state == MAX_4_S);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_beat <= 1'b0;
    end else if (beat) begin
      seen_beat <= 1'b1;
    end
  end

  // Open input and quiet output until traffic starts
  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_beat |-> (s_ready && !m_valid && !m_last))
    else begin fail_count++; $error("output active or input blocked before first beat"); end

  // Exactly one blocked cycle per MAX_4 beat
  a_stall_once: assert property (@(posedge clk) disable iff (!rst_n)
    max_4_beat |=> !s_ready ##1 s_ready)
    else begin fail_count++; $error("s_ready not low for exactly one cycle after MAX_4"); end

  a_no_stall_max_2: assert property (@(posedge clk) disable iff (!rst_n)
    beat && (state == MAX_2_S) |=> s_ready)
    else begin fail_count++; $error("s_ready dropped after a MAX_2 beat"); end

  // Pass-through one cycle out, full keep
  a_pass_timing: assert property (@(posedge clk) disable iff (!rst_n)
    beat && s_user[I_IS_NOT_MAX] |=> m_valid && (m_keep == '1))
    else begin fail_count++; $error("pass-through beat missing or keep wrong"); end

  // Pooled two cycles out, copy 1 dropped
  a_pool_timing: assert property (@(posedge clk) disable iff (!rst_n)
    max_4_beat && s_user[I_IS_MAX] |-> ##2 (m_valid &&
      (m_keep == {{LANES{1'b0}}, {LANES{1'b1}}})))
    else begin fail_count++; $error("pooled beat missing or keep wrong"); end

  // Both mode, every MAX_4 output closes a packet
  a_both_last: assert property (@(posedge clk) disable iff (!rst_n)
    max_4_beat && s_user[I_IS_MAX] && s_user[I_IS_NOT_MAX] |=> m_last ##1 m_last)
    else begin fail_count++; $error("m_last low on a both-mode MAX_4 output"); end

  a_last_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
    m_last |-> m_valid)
    else begin fail_count++; $error("m_last high without m_valid"); end

endmodule

`default_nettype wire

// ==== test/maxpool_engine_tb.sv ====
// Testbench for the streaming 2x2 max-pooling engine
// Drives pass-through, max and mixed block traffic with random gaps and
// checks every output beat against a queue-based reference model
`timescale 1ns/1ps
`default_nettype none

module maxpool_engine_tb;

  import maxpool_pkg::*;

  localparam int UNITS      = DEF_UNITS;
  localparam int GROUPS     = DEF_GROUPS;
  localparam int MEMBERS    = DEF_MEMBERS;
  localparam int WORD_WIDTH = DEF_WORD_WIDTH;
  localparam int LANES      = GROUPS * UNITS;
  localparam int HALF_W     = LANES * WORD_WIDTH;
  localparam int DATA_W     = 2 * HALF_W;
  localparam int CLK_PERIOD = 4;
  localparam logic [31:0] SEED = 32'h0e862175;
  // 4 single blocks and 8 block pairs
  localparam int TOTAL_BEATS = 4 * MEMBERS + 8 * 2 * MEMBERS;
  // Gaps plus stall stay under 4 cycles per beat
  localparam int TIMEOUT_NS  = TOTAL_BEATS * 4 * CLK_PERIOD + 100 * CLK_PERIOD;

  logic                  clk;
  logic                  rst_n;
  logic                  s_valid;
  logic [DATA_W-1:0]     s_data;
  logic [USER_WIDTH-1:0] s_user;
  logic                  s_ready;
  logic                  m_valid;
  logic [DATA_W-1:0]     m_data;
  logic [2*LANES-1:0]    m_keep;
  logic                  m_last;

  int unsigned cyc = 0;
  int          value_errors = 0;
  int          assert_errors;

  // Expected output beats, oldest first
  int unsigned        exp_cyc_q  [$];
  logic [DATA_W-1:0]  exp_data_q [$];
  logic [DATA_W-1:0]  exp_mask_q [$];
  logic [2*LANES-1:0] exp_keep_q [$];
  logic               exp_last_q [$];

  // Model of block position and pair half
  logic model_max_4 = 1'b0;
  int   model_count = 0;
  logic signed [WORD_WIDTH-1:0] stored_row [MEMBERS][LANES];

  maxpool_engine u_maxpool_engine (.*);

  bind maxpool_engine maxpool_engine_assertions #(
    .LANES   (GROUPS * UNITS)
  ) u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .beat    (beat),
    .s_ready (s_ready),
    .s_user  (s_user),
    .state   (state),
    .m_valid (m_valid),
    .m_keep  (m_keep),
    .m_last  (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // ************************************************************************
  // Reference model
  // ************************************************************************

  function automatic logic signed [WORD_WIDTH-1:0] larger(
    input logic signed [WORD_WIDTH-1:0] a,
    input logic signed [WORD_WIDTH-1:0] b
  );
    return (a >= b) ? a : b;
  endfunction

  task automatic push_expected(input int unsigned at, input logic [DATA_W-1:0] d,
                               input logic [DATA_W-1:0] mask,
                               input logic [2*LANES-1:0] keep, input logic last);
    exp_cyc_q.push_back(at);
    exp_data_q.push_back(d & mask);
    exp_mask_q.push_back(mask);
    exp_keep_q.push_back(keep);
    exp_last_q.push_back(last);
  endtask

  task automatic drop_head();
    void'(exp_cyc_q.pop_front());
    void'(exp_data_q.pop_front());
    void'(exp_mask_q.pop_front());
    void'(exp_keep_q.pop_front());
    void'(exp_last_q.pop_front());
  endtask

  // One accepted beat, taken at the clock edge after this sample point
  task automatic record_beat(input logic [DATA_W-1:0] d, input logic [USER_WIDTH-1:0] u);
    logic                         last_member;
    logic                         both;
    logic signed [WORD_WIDTH-1:0] row_max;
    logic [DATA_W-1:0]            pool_data;
    last_member = (model_count == MEMBERS - 1);
    both        = u[I_IS_MAX] && u[I_IS_NOT_MAX];
    pool_data   = '0;
    // Pass-through one cycle later, every beat of a both-mode MAX_4 block closes
    if (u[I_IS_NOT_MAX])
      push_expected(cyc + 1, d, '1, '1, last_member || (both && model_max_4));
    if (u[I_IS_MAX]) begin
      for (int l = 0; l < LANES; l++) begin
        row_max = larger(d[l*WORD_WIDTH +: WORD_WIDTH],
                         d[HALF_W + l*WORD_WIDTH +: WORD_WIDTH]);
        if (!model_max_4)
          stored_row[model_count][l] = row_max;
        else
          pool_data[l*WORD_WIDTH +: WORD_WIDTH] = larger(stored_row[model_count][l], row_max);
      end
      // Pooled beat two cycles later, copy 1 dropped
      if (model_max_4)
        push_expected(cyc + 2, pool_data, {{HALF_W{1'b0}}, {HALF_W{1'b1}}},
                      {{LANES{1'b0}}, {LANES{1'b1}}}, last_member || both);
      if (last_member) model_max_4 = !model_max_4;
    end
    model_count = last_member ? 0 : model_count + 1;
  endtask

  task automatic check_output();
    if (m_valid && exp_cyc_q.size() == 0) begin
      $display("Unexpected output beat at cycle %0d", cyc);
      value_errors++;
    end else if (m_valid) begin
      if (exp_cyc_q[0] != cyc) begin
        $display("Output beat at cycle %0d, expected at cycle %0d", cyc, exp_cyc_q[0]);
        value_errors++;
      end
      if ((m_data & exp_mask_q[0]) !== exp_data_q[0]) begin
        $display("ERR m_data: got %h expected %h", m_data & exp_mask_q[0], exp_data_q[0]);
        value_errors++;
      end
      if (m_keep !== exp_keep_q[0]) begin
        $display("ERR m_keep: got %h expected %h", m_keep, exp_keep_q[0]);
        value_errors++;
      end
      if (m_last !== exp_last_q[0]) begin
        $display("ERR m_last: got %h expected %h", m_last, exp_last_q[0]);
        value_errors++;
      end
      drop_head();
    end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] < cyc) begin
      $display("Output beat due at cycle %0d never appeared", exp_cyc_q[0]);
      value_errors++;
      drop_head();
    end
  endtask

  // Sample mid-cycle, well clear of both drive and capture
  always @(negedge clk) begin
    if (rst_n && s_valid && s_ready) record_beat(s_data, s_user);
    if (rst_n) check_output();
  end

  // ************************************************************************
  // Stimulus
  // ************************************************************************

  // Flavor 1 mixes in signed extremes, flavor 2 is all negative
  function automatic logic [DATA_W-1:0] make_beat(input int flavor);
    logic [DATA_W-1:0]     d;
    logic [WORD_WIDTH-1:0] w;
    for (int i = 0; i < 2 * LANES; i++) begin
      w = WORD_WIDTH'($urandom);
      if (flavor == 1) begin
        case ($urandom % 4)
          0: w = {1'b1, {(WORD_WIDTH-1){1'b0}}};
          1: w = {1'b0, {(WORD_WIDTH-1){1'b1}}};
          2: w = '1;
          default: ;
        endcase
      end else if (flavor == 2) begin
        w[WORD_WIDTH-1] = 1'b1;
      end
      d[i*WORD_WIDTH +: WORD_WIDTH] = w;
    end
    return d;
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic send_beat(input logic [USER_WIDTH-1:0] mode, input int flavor);
    int gap;
    gap     = ($urandom % 4 == 0) ? 1 + $urandom % 2 : 0;
    s_user  = mode;
    s_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    s_valid = 1'b1;
    s_data  = make_beat(flavor);
    @(negedge clk);
    while (!s_ready) @(negedge clk);
    @(posedge clk);
    #1;
    s_valid = 1'b0;
  endtask

  // One block for pass-through, a block pair otherwise
  task automatic run_step(input logic [USER_WIDTH-1:0] mode, input int flavor);
    repeat ((mode == 2'b01) ? MEMBERS : 2 * MEMBERS) send_beat(mode, flavor);
    // Mode held through the stall slot of the last pooled beat
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    s_user  = 2'b01;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_step(2'b01, 0);
    run_step(2'b01, 0);
    run_step(2'b10, 0);
    run_step(2'b10, 0);
    run_step(2'b11, 0);
    run_step(2'b11, 0);
    // Signed corners, mode switching between pairs
    run_step(2'b10, 1);
    run_step(2'b11, 2);
    run_step(2'b01, 1);
    run_step(2'b10, 2);
    run_step(2'b11, 1);
    run_step(2'b01, 2);
    repeat (4) @(posedge clk);
    #1;
    if (exp_cyc_q.size() != 0) begin
      $display("%0d expected output beats never appeared", exp_cyc_q.size());
      value_errors += exp_cyc_q.size();
    end
    assert_errors = u_maxpool_engine.u_assertions.fail_count;
    $display("Summary: %0d value errors, %0d assertion failures", value_errors, assert_errors);
    if (value_errors == 0 && assert_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
src/maxpool_pkg.sv
src/member_counter.sv
src/maxpool_fsm.sv
src/max_datapath.sv
src/pool_output.sv
src/maxpool_engine.sv
test/maxpool_engine_assertions.sv
test/maxpool_engine_tb.sv
